//--- ibuf_rd.f
+incdir+.
ibuf_rd_pkg.sv
ibuf_rd_req_gen.sv
ibuf_rd_cpl_filter.sv
ibuf_rd_cpl_writer.sv
ibuf_rd_tag_table.sv
ibuf_rd_commit.sv
ibuf_rd_top.sv
ibuf_rd_checker.sv
tb_ibuf_rd.sv

//--- tb_ibuf_rd.sv
/*
 * ibuf read engine testbench
 * clock, reset, host memory model with shuffled completions and watchdog
 */
`timescale 1ns/1ps
`default_nettype none

module tb_ibuf_rd;

    localparam int TOTAL_QW = 200 + 96 + 200 + 264 + 640;
    localparam int HOLD_CYC = 700;
    localparam time LIMIT   = (TOTAL_QW * 20 + HOLD_CYC) * 4 + 20000;

    logic clk = 1'b0;
    logic rst;
    logic lbuf_en, rd_ack, trn_rsof_n, trn_reof_n, trn_rsrc_rdy_n;
    logic lbuf_dn, rd, wr_en, hold_cons, desc_end, inj_go, inj_done;
    logic [2:0] cfg;
    ibuf_rd_pkg::host_addr_t lbuf_addr, hst_addr;
    ibuf_rd_pkg::xfer_len_t  lbuf_len;
    ibuf_rd_pkg::tag_t       rd_tag;
    ibuf_rd_pkg::qw_len_t    rd_qw;
    ibuf_rd_pkg::qw_t        trn_rd, wr_data;
    ibuf_rd_pkg::ibuf_ptr_t  committed_prod, committed_cons;
    ibuf_rd_pkg::ibuf_addr_t wr_addr;
    ibuf_rd_pkg::host_addr_t tag_addr [8];     // next completion address per tag
    int tag_left [8];                          // QWs still to return per tag
    int err_cnt, total, ntests, r, found, i;
    int inj_errs;                              // error count before the injected TLPs
    int seed, ack_seed;

    always #2 clk = ~clk;

    ibuf_rd_top uut (
        .clk, .rst, .lbuf_en, .lbuf_addr, .lbuf_len, .lbuf_dn,
        .rd, .hst_addr, .rd_qw, .rd_ack, .rd_tag,
        .trn_rd, .trn_rsof_n, .trn_reof_n, .trn_rsrc_rdy_n,
        .cfg_max_rd_req_size(cfg), .committed_prod, .committed_cons,
        .wr_en, .wr_addr, .wr_data
    );

    ibuf_rd_checker u_chk (
        .clk, .rst, .lbuf_en, .lbuf_addr, .lbuf_len, .lbuf_dn, .rd, .rd_ack,
        .hst_addr, .rd_qw, .cfg_max_rd_req_size(cfg), .committed_cons,
        .committed_prod, .wr_en, .wr_addr, .wr_data, .desc_end, .err_cnt
    );

    function automatic logic [31:0] host_dw(input ibuf_rd_pkg::host_addr_t a);
        return a[31:0] * 32'h9E3779B1 ^ a[63:32];
    endfunction

    // one 16-DW TLP, header in beats 0 and 1, random idle gaps
    task automatic send_tlp(input logic [6:0] ft, input logic [2:0] st, input logic [4:0] tg,
                            input ibuf_rd_pkg::host_addr_t a);
        ibuf_rd_pkg::qw_t d;
        int b;
        for (b = 0; b < 10; b++) begin
            while (($random(seed) & 3) == 0) begin
                trn_rsrc_rdy_n = 1'b1;
                @(negedge clk);
            end
            d = '0;
            if (b == 0) begin
                d[62:56] = ft;
                d[41:32] = 10'd16;
                d[15:13] = st;
            end else if (b == 1) begin
                d[44:40] = tg;
                d[31:0]  = host_dw(a);
            end else begin
                d[63:32] = host_dw(a + 64'(8 * (b - 1) - 4));
                d[31:0]  = (b == 9) ? 32'h0 : host_dw(a + 64'(8 * (b - 1)));
            end
            trn_rd         = d;
            trn_rsof_n     = (b != 0);
            trn_reof_n     = (b != 9);
            trn_rsrc_rdy_n = 1'b0;
            @(negedge clk);
        end
        trn_rsrc_rdy_n = 1'b1;
        trn_rsof_n     = 1'b1;
        trn_reof_n     = 1'b1;
    endtask

    task automatic run_desc(input logic [2:0] size, input ibuf_rd_pkg::host_addr_t a,
                            input int len, input int hold);
        int errs0;
        errs0 = err_cnt;
        @(negedge clk);
        hold_cons <= (hold > 0);
        cfg       <= size;
        lbuf_addr <= a;
        lbuf_len  <= len;
        lbuf_en   <= 1'b1;
        if (hold > 0) begin
            repeat (hold) @(negedge clk);
            hold_cons <= 1'b0;              // let the consumer catch up
        end
        while (!lbuf_dn) @(negedge clk);
        lbuf_en <= 1'b0;
        total += len;
        while (committed_prod != ibuf_rd_pkg::ibuf_ptr_t'(total)) @(negedge clk);
        repeat (4) @(negedge clk);
        desc_end <= 1'b1;
        @(negedge clk);
        desc_end <= 1'b0;
        @(negedge clk);
        ntests++;
        $display("test %0d size code %0d, %0d QWs: %0d errors", ntests, size, len,
                 err_cnt - errs0);
    endtask

    // consumer follows the producer unless held
    always @(negedge clk) if (!hold_cons) committed_cons <= committed_prod;

    always @(posedge clk) begin
        if (rd_ack) begin
            tag_addr[rd_tag] <= hst_addr;
            tag_left[rd_tag] <= int'(rd_qw);
        end
    end

    // acks with random delay, tags handed out in order
    initial begin
        rd_ack   = 1'b0;
        rd_tag   = '0;
        ack_seed = 18597;
        forever begin
            @(negedge clk);
            if (rd && !rst) begin
                repeat ($random(ack_seed) & 7) @(negedge clk);
                rd_ack <= 1'b1;
                @(negedge clk);
                rd_ack <= 1'b0;
                rd_tag <= rd_tag + 1'b1;
            end
        end
    end

    // completions of open tags in shuffled order, bad ones on request
    initial begin
        seed = 18597;
        for (i = 0; i < 8; i++) tag_left[i] = 0;
        forever begin
            @(negedge clk);
            if (inj_go && !inj_done) begin
                send_tlp(7'b0000000, 3'b000, 5'd0, 64'h2000);       // memory read
                send_tlp(7'b1001010, 3'b001, 5'd0, 64'h2040);       // unsupported request
                send_tlp(7'b1001010, 3'b000, 5'b01000, 64'h2080);   // foreign tag base
                inj_done <= 1'b1;
            end else begin
                repeat ($random(seed) & 7) @(negedge clk);
                r = $random(seed) & 7;
                found = -1;
                for (i = 0; i < 8; i++)
                    if (found < 0 && tag_left[(r + i) & 7] > 0) found = (r + i) & 7;
                if (found >= 0) begin
                    send_tlp(7'b1001010, 3'b000, 5'(found), tag_addr[found]);
                    tag_left[found] -= 8;
                    tag_addr[found] += 64;
                end
            end
        end
    end

    initial begin
        #(LIMIT);
        $display("watchdog expired before the tests finished");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        lbuf_en = 1'b0;
        lbuf_addr = '0;
        lbuf_len = '0;
        cfg = 3'd0;
        trn_rd = '0;
        trn_rsof_n = 1'b1;
        trn_reof_n = 1'b1;
        trn_rsrc_rdy_n = 1'b1;
        committed_cons = '0;
        hold_cons = 1'b0;
        desc_end = 1'b0;
        inj_go = 1'b0;
        inj_done = 1'b0;
        total = 0;
        ntests = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        run_desc(3'd0, 64'h0000_0001_1000_0040, 200, 0);  // enough small reads to use all 8 tags
        run_desc(3'd1, 64'h0000_0000_2000_0000, 96, 0);
        run_desc(3'd2, 64'h0000_0000_3000_01c0, 200, 0);
        run_desc(3'd3, 64'h0000_0002_4000_0000, 264, 0);
        run_desc(3'd5, 64'h0000_0000_5000_0400, 640, HOLD_CYC);  // ring full for a while
        inj_errs = err_cnt;
        inj_go <= 1'b1;
        while (!inj_done) @(negedge clk);
        repeat (20) @(negedge clk);
        ntests++;
        $display("test %0d rejected completions: %0d errors", ntests, err_cnt - inj_errs);
        $display("%0d tests run, %0d errors", ntests, err_cnt);
        if (err_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- ibuf_rd_checker.sv
/*
 * ibuf read engine checker
 * watches the DUT ports and compares ring writes, requests and the
 * committed producer pointer against the expected behavior
 */
`timescale 1ns/1ps
`default_nettype none

module ibuf_rd_checker (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    lbuf_en,
    input  wire ibuf_rd_pkg::host_addr_t lbuf_addr,
    input  wire ibuf_rd_pkg::xfer_len_t  lbuf_len,
    input  wire logic                    lbuf_dn,
    input  wire logic                    rd,
    input  wire logic                    rd_ack,
    input  wire ibuf_rd_pkg::host_addr_t hst_addr,
    input  wire ibuf_rd_pkg::qw_len_t    rd_qw,
    input  wire logic [2:0]              cfg_max_rd_req_size,
    input  wire ibuf_rd_pkg::ibuf_ptr_t  committed_cons,
    input  wire ibuf_rd_pkg::ibuf_ptr_t  committed_prod,
    input  wire logic                    wr_en,
    input  wire ibuf_rd_pkg::ibuf_addr_t wr_addr,
    input  wire ibuf_rd_pkg::qw_t        wr_data,
    input  wire logic                    desc_end,   // tb marks the descriptor finished
    output int                           err_cnt
);

    ibuf_rd_pkg::host_addr_t d_addr;
    ibuf_rd_pkg::qw_t        exp_qw;
    int d_len, d_start, acked, writes, dn_cnt;
    int issued, contig, prod_tot, prev_prod, lim, idx, delta, i;
    int lap [512];                              // writes per slot in this descriptor
    logic flag [512];                           // written, not yet contiguous
    int req_end [$];                            // end pointers of open requests
    logic en_q, active;

    function automatic logic [31:0] swap32(input logic [31:0] d);
        return {d[7:0], d[15:8], d[23:16], d[31:24]};
    endfunction

    // expected ring QW: two host DWs, each swapped, first DW on top
    function automatic ibuf_rd_pkg::qw_t ref_qw(input ibuf_rd_pkg::host_addr_t a, input int n);
        ibuf_rd_pkg::host_addr_t p;
        logic [31:0] d0, d1;
        p  = a + 64'(8 * n);
        d0 = p[31:0] * 32'h9E3779B1 ^ p[63:32];
        d1 = (p[31:0] + 32'd4) * 32'h9E3779B1 ^ p[63:32];
        return {swap32(d0), swap32(d1)};
    endfunction

    function automatic int size_qws(input logic [2:0] c);
        case (c)
            3'd0:    return 16;
            3'd1:    return 32;
            3'd2:    return 64;
            default: return 128;
        endcase
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            err_cnt = 0;
            en_q = 1'b0;
            active = 1'b0;
            issued = 0;
            contig = 0;
            prod_tot = 0;
            prev_prod = 0;
            req_end.delete();
            for (i = 0; i < 512; i++) flag[i] = 1'b0;
        end else begin
            //////////////////////////////////////////////////////////////////////
            // descriptor start
            //////////////////////////////////////////////////////////////////////
            if (lbuf_en && !en_q) begin
                active  = 1'b1;
                d_addr  = lbuf_addr;
                d_len   = int'(lbuf_len);
                d_start = issued;
                acked   = 0;
                writes  = 0;
                dn_cnt  = 0;
                for (i = 0; i < 512; i++) lap[i] = 0;
            end
            en_q = lbuf_en;

            if (rd && rd_ack) begin
                lim = size_qws(cfg_max_rd_req_size);
                if (rd_qw == 0 || int'(rd_qw) > lim) begin
                    $display("Error at %0t: rd_qw limit %0d got %0d", $time, lim, rd_qw);
                    err_cnt++;
                end
                if (hst_addr != d_addr + 64'(8 * acked)) begin
                    $display("Error at %0t: hst_addr expected %h got %h",
                             $time, d_addr + 64'(8 * acked), hst_addr);
                    err_cnt++;
                end
                if (((issued + int'(rd_qw) - int'(committed_cons)) & 1023) > 512) begin
                    $display("request at %0t runs past the consumer pointer", $time);
                    err_cnt++;
                end
                acked  += int'(rd_qw);
                issued += int'(rd_qw);
                req_end.push_back(issued);
                if (req_end.size() > 8) begin
                    $display("more than 8 requests outstanding at %0t", $time);
                    err_cnt++;
                end
            end

            if (lbuf_dn) begin
                dn_cnt++;
                if (acked != d_len) begin
                    $display("lbuf_dn at %0t before all requests were acked", $time);
                    err_cnt++;
                end
            end

            if (wr_en) begin
                if (!active) begin
                    $display("ring write at %0t with no descriptor active", $time);
                    err_cnt++;
                end else begin
                    idx = ((int'(wr_addr) - d_start) & 511) + 512 * lap[wr_addr];
                    lap[wr_addr]++;
                    exp_qw = ref_qw(d_addr, idx);
                    if (idx >= d_len) begin
                        $display("slot %0d written too often at %0t", wr_addr, $time);
                        err_cnt++;
                    end else if (wr_data != exp_qw) begin
                        $display("Error at %0t: wr_data expected %h got %h",
                                 $time, exp_qw, wr_data);
                        err_cnt++;
                    end
                end
                writes++;
                flag[wr_addr] = 1'b1;
                while (flag[contig & 511]) begin   // extend the written run
                    flag[contig & 511] = 1'b0;
                    contig++;
                end
            end

            //////////////////////////////////////////////////////////////////////
            // producer pointer
            //////////////////////////////////////////////////////////////////////
            if (int'(committed_prod) != prev_prod) begin
                delta = (int'(committed_prod) - prev_prod) & 1023;
                if (!active) begin
                    $display("committed_prod moved at %0t with no descriptor active", $time);
                    err_cnt++;
                end
                if (delta > 512) begin
                    $display("committed_prod went backwards at %0t", $time);
                    err_cnt++;
                end
                prod_tot += delta;
                if (prod_tot > contig) begin
                    $display("committed_prod passed unwritten data at %0t", $time);
                    err_cnt++;
                end
                prev_prod = int'(committed_prod);
                while (req_end.size() > 0 && req_end[0] <= prod_tot) void'(req_end.pop_front());
            end

            if (desc_end) begin
                if (writes != d_len || acked != d_len || dn_cnt != 1) begin
                    $display("descriptor ended with %0d writes, %0d QWs acked, %0d lbuf_dn",
                             writes, acked, dn_cnt);
                    err_cnt++;
                end
                if (prod_tot != issued || contig != issued) begin
                    $display("committed_prod short of the transferred total at %0t", $time);
                    err_cnt++;
                end
                active = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- ibuf_rd_top.sv
/*
 * ibuf read engine top
 * host-to-card DMA reads into the receive ring
 */
`timescale 1ns/1ps
`default_nettype none

module ibuf_rd_top (
    input  wire logic                    clk,
    input  wire logic                    rst,
    // descriptor
    input  wire logic                    lbuf_en,
    input  wire ibuf_rd_pkg::host_addr_t lbuf_addr,
    input  wire ibuf_rd_pkg::xfer_len_t  lbuf_len,
    output logic                         lbuf_dn,
    // memory read requests
    output logic                         rd,
    output ibuf_rd_pkg::host_addr_t      hst_addr,
    output ibuf_rd_pkg::qw_len_t         rd_qw,
    input  wire logic                    rd_ack,
    input  wire ibuf_rd_pkg::tag_t       rd_tag,
    // TRN receive
    input  wire ibuf_rd_pkg::qw_t        trn_rd,
    input  wire logic                    trn_rsof_n,
    input  wire logic                    trn_reof_n,
    input  wire logic                    trn_rsrc_rdy_n,
    input  wire logic [2:0]              cfg_max_rd_req_size,
    // ring
    output ibuf_rd_pkg::ibuf_ptr_t       committed_prod,
    input  wire ibuf_rd_pkg::ibuf_ptr_t  committed_cons,
    output logic                         wr_en,
    output ibuf_rd_pkg::ibuf_addr_t      wr_addr,
    output ibuf_rd_pkg::qw_t             wr_data
);

    ibuf_rd_pkg::trn_beat_t beat;
    ibuf_rd_pkg::new_req_t  new_req;
    ibuf_rd_pkg::cpl_hdr_t  cpl_hdr;
    ibuf_rd_pkg::tag_t      wr_tag;
    ibuf_rd_pkg::tag_t      ret_tag;
    ibuf_rd_pkg::qw_len_t   wr_qws;
    ibuf_rd_pkg::ibuf_ptr_t wr_base;
    ibuf_rd_pkg::ibuf_ptr_t ret_end;
    ibuf_rd_pkg::os_cnt_t   retired_cnt;
    logic                   new_req_vld;
    logic                   cpl_acc;
    logic                   wr_done;
    logic                   retire;
    logic                   ret_entry_done;

    // TRN input register, flipped to active high
    always_ff @(posedge clk) begin
        beat.data <= trn_rd;
        beat.sof  <= ~trn_rsof_n;
        beat.eof  <= ~trn_reof_n;
        if (rst) beat.vld <= 1'b0;
        else beat.vld <= ~trn_rsrc_rdy_n;
    end

    ibuf_rd_req_gen u_req_gen (
        .clk, .rst, .lbuf_en, .lbuf_addr, .lbuf_len, .cfg_max_rd_req_size,
        .committed_cons, .rd_ack, .rd_tag, .retired_cnt,
        .lbuf_dn, .rd, .hst_addr, .rd_qw, .new_req, .new_req_vld
    );

    ibuf_rd_cpl_filter u_cpl_filter (
        .clk, .rst, .beat, .cpl_hdr, .cpl_acc
    );

    ibuf_rd_cpl_writer u_cpl_writer (
        .clk, .rst, .beat, .cpl_hdr, .cpl_acc, .wr_base,
        .wr_en, .wr_addr, .wr_data, .wr_tag, .wr_qws, .wr_done
    );

    ibuf_rd_tag_table u_tag_table (
        .clk, .rst, .new_req, .new_req_vld, .wr_tag, .wr_qws, .wr_done,
        .ret_tag, .retire, .wr_base, .ret_entry_done, .ret_end
    );

    ibuf_rd_commit u_commit (
        .clk, .rst, .ret_entry_done, .ret_end,
        .ret_tag, .retire, .retired_cnt, .committed_prod
    );

endmodule

`default_nettype wire

//--- ibuf_rd_commit.sv
/*
 * producer commit
 * retires tags in issue order and publishes the committed producer pointer
 */
`timescale 1ns/1ps
`default_nettype none

module ibuf_rd_commit (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   ret_entry_done,
    input  wire ibuf_rd_pkg::ibuf_ptr_t ret_end,
    output ibuf_rd_pkg::tag_t           ret_tag,
    output logic                        retire,
    output ibuf_rd_pkg::os_cnt_t        retired_cnt,
    output ibuf_rd_pkg::ibuf_ptr_t      committed_prod
);

    // tags are handed out in ascending order mod 8, so the oldest
    // outstanding request is always the one at ret_tag
    always_ff @(posedge clk) begin
        if (rst) begin
            ret_tag        <= '0;
            retire         <= 1'b0;
            retired_cnt    <= '0;
            committed_prod <= '0;
        end else begin
            retire <= 1'b0;
            if (retire) begin
                ret_tag     <= ret_tag + 1'b1;      // move to next oldest
                retired_cnt <= retired_cnt + 1'b1;
            end else if (ret_entry_done) begin
                committed_prod <= ret_end;
                retire         <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- ibuf_rd_tag_table.sv
/*
 * per-tag bookkeeping
 * next ring write pointer, requested and received QWs of each tag
 */
`timescale 1ns/1ps
`default_nettype none

`include "ibuf_rd_macros.svh"

module ibuf_rd_tag_table (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire ibuf_rd_pkg::new_req_t  new_req,
    input  wire logic                   new_req_vld,
    input  wire ibuf_rd_pkg::tag_t      wr_tag,
    input  wire ibuf_rd_pkg::qw_len_t   wr_qws,
    input  wire logic                   wr_done,
    input  wire ibuf_rd_pkg::tag_t      ret_tag,
    input  wire logic                   retire,
    output ibuf_rd_pkg::ibuf_ptr_t      wr_base,
    output logic                        ret_entry_done,
    output ibuf_rd_pkg::ibuf_ptr_t      ret_end
);

    localparam int NTAG = 1 << `OSRW;

    ibuf_rd_pkg::ibuf_ptr_t wptr    [NTAG];  // advances with each completion
    ibuf_rd_pkg::qw_len_t   req_len [NTAG];
    ibuf_rd_pkg::qw_len_t   rcv_len [NTAG];
    logic [NTAG-1:0]        busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            if (retire) busy[ret_tag] <= 1'b0;
            if (new_req_vld) busy[new_req.tag] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_done) begin
            wptr[wr_tag]    <= wptr[wr_tag] + ibuf_rd_pkg::ibuf_ptr_t'(wr_qws);
            rcv_len[wr_tag] <= rcv_len[wr_tag] + wr_qws;
        end
        if (retire) rcv_len[ret_tag] <= '0;
        // a fresh request takes over its entry
        if (new_req_vld) begin
            wptr[new_req.tag]    <= new_req.base;
            req_len[new_req.tag] <= new_req.qws;
            rcv_len[new_req.tag] <= '0;
        end
    end

    assign wr_base = wptr[wr_tag];
    assign ret_end = wptr[ret_tag];  // end of data once complete

    assign ret_entry_done = busy[ret_tag] && (rcv_len[ret_tag] == req_len[ret_tag]);

endmodule

`default_nettype wire

//--- ibuf_rd_cpl_writer.sv
/*
 * completion payload writer
 * realigns DWs across beats, byte swaps them and writes QWs to the ring
 */
`timescale 1ns/1ps
`default_nettype none

`include "ibuf_rd_macros.svh"

module ibuf_rd_cpl_writer (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire ibuf_rd_pkg::trn_beat_t beat,
    input  wire ibuf_rd_pkg::cpl_hdr_t  cpl_hdr,
    input  wire logic                   cpl_acc,
    input  wire ibuf_rd_pkg::ibuf_ptr_t wr_base,
    output logic                        wr_en,
    output ibuf_rd_pkg::ibuf_addr_t     wr_addr,
    output ibuf_rd_pkg::qw_t            wr_data,
    output ibuf_rd_pkg::tag_t           wr_tag,
    output ibuf_rd_pkg::qw_len_t        wr_qws,
    output logic                        wr_done
);

    ibuf_rd_pkg::trn_beat_t  beat_q;     // lines up with cpl_acc
    ibuf_rd_pkg::wr_state_t  state;
    ibuf_rd_pkg::tag_t       tag_r;
    ibuf_rd_pkg::ibuf_addr_t addr_r;
    ibuf_rd_pkg::qw_len_t    cnt;
    ibuf_rd_pkg::qw_len_t    exp_qws;
    logic [31:0]             carry;      // swapped DW waiting for its partner
    logic                    fits;

    function automatic logic [31:0] dw_swap(input logic [31:0] d);
        return {d[7:0], d[15:8], d[23:16], d[31:24]};
    endfunction

    // new tag looks up its base in the accept cycle
    assign wr_tag = cpl_acc ? cpl_hdr.tag : tag_r;
    assign fits   = cnt < exp_qws;

    always_ff @(posedge clk) begin
        beat_q <= beat;
        if (rst) beat_q.vld <= 1'b0;
    end

    //////////////////////////////////////////////////////////////////////
    // payload FSM
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ibuf_rd_pkg::WR_IDLE;
            wr_en   <= 1'b0;
            wr_done <= 1'b0;
        end else begin
            wr_en   <= 1'b0;
            wr_done <= 1'b0;
            case (state)
                ibuf_rd_pkg::WR_IDLE: begin
                    if (cpl_acc) begin
                        tag_r   <= cpl_hdr.tag;
                        exp_qws <= {1'b0, cpl_hdr.len[9:1]};
                        addr_r  <= wr_base[`IBUF_AW-1:0];
                        carry   <= dw_swap(beat_q.data[31:0]);  // first payload DW
                        cnt     <= '0;
                        state   <= ibuf_rd_pkg::WR_DATA;
                    end
                end
                ibuf_rd_pkg::WR_DATA: begin
                    if (beat_q.vld) begin
                        if (fits) begin  // never past the header length
                            wr_en   <= 1'b1;
                            wr_addr <= addr_r;
                            wr_data <= {carry, dw_swap(beat_q.data[63:32])};
                            addr_r  <= addr_r + 1'b1;
                            cnt     <= cnt + 1'b1;
                        end
                        carry <= dw_swap(beat_q.data[31:0]);
                        if (beat_q.eof) begin
                            wr_done <= 1'b1;
                            wr_qws  <= fits ? cnt + 1'b1 : cnt;
                            state   <= ibuf_rd_pkg::WR_IDLE;
                        end
                    end
                end
                default: state <= ibuf_rd_pkg::WR_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- ibuf_rd_cpl_filter.sv
/*
 * completion filter
 * accepts successful completions with data that carry our tag base
 */
`timescale 1ns/1ps
`default_nettype none

`include "ibuf_rd_macros.svh"

module ibuf_rd_cpl_filter (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire ibuf_rd_pkg::trn_beat_t beat,
    output ibuf_rd_pkg::cpl_hdr_t       cpl_hdr,
    output logic                        cpl_acc
);

    logic                 hdr2;       // first header beat passed
    ibuf_rd_pkg::dw_len_t len_r;

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr2    <= 1'b0;
            cpl_acc <= 1'b0;
        end else begin
            cpl_acc <= 1'b0;
            if (!hdr2) begin
                len_r <= beat.data[41:32];
                // fmt/type in DW0, status in DW1
                if (beat.vld && beat.sof &&
                    beat.data[62:56] == `CPL_W_DATA_FMT_TYPE &&
                    beat.data[15:13] == `CPL_STATUS_SC) begin
                    hdr2 <= 1'b1;
                end
            end else if (beat.vld) begin
                hdr2 <= 1'b0;
                if (beat.data[44:40+`OSRW] == `RQ_TAG_BASE) begin
                    cpl_hdr.tag <= beat.data[40 +: `OSRW];
                    cpl_hdr.len <= len_r;
                    cpl_acc     <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- ibuf_rd_req_gen.sv
/*
 * read request generator
 * splits a descriptor into memory reads bounded by max read size,
 * free ring space and the outstanding tag limit
 */
`timescale 1ns/1ps
`default_nettype none

`include "ibuf_rd_macros.svh"

module ibuf_rd_req_gen (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   lbuf_en,
    input  wire ibuf_rd_pkg::host_addr_t lbuf_addr,
    input  wire ibuf_rd_pkg::xfer_len_t lbuf_len,
    input  wire logic [2:0]             cfg_max_rd_req_size,
    input  wire ibuf_rd_pkg::ibuf_ptr_t committed_cons,
    input  wire logic                   rd_ack,
    input  wire ibuf_rd_pkg::tag_t      rd_tag,
    input  wire ibuf_rd_pkg::os_cnt_t   retired_cnt,
    output logic                        lbuf_dn,
    output logic                        rd,
    output ibuf_rd_pkg::host_addr_t     hst_addr,
    output ibuf_rd_pkg::qw_len_t        rd_qw,
    output ibuf_rd_pkg::new_req_t       new_req,
    output logic                        new_req_vld
);

    localparam int NEED_W = `IBUF_AW + 2;
    localparam logic [NEED_W-1:0] RING_QWS = 1 << `IBUF_AW;
    localparam ibuf_rd_pkg::os_cnt_t OS_MAX = 1 << `OSRW;

    ibuf_rd_pkg::req_state_t state;
    ibuf_rd_pkg::xfer_len_t  qw_left;
    ibuf_rd_pkg::qw_len_t    mx_qw;
    ibuf_rd_pkg::qw_len_t    req_qw;
    ibuf_rd_pkg::ibuf_ptr_t  iprod;          // issue pointer into the ring
    ibuf_rd_pkg::ibuf_ptr_t  used;
    ibuf_rd_pkg::os_cnt_t    issued_cnt;
    ibuf_rd_pkg::os_cnt_t    os_req;
    logic [NEED_W-1:0]       need;

    assign used   = iprod - committed_cons;
    assign need   = NEED_W'(used) + NEED_W'(req_qw);
    assign os_req = issued_cnt - retired_cnt;

    always_ff @(posedge clk) begin
        case (cfg_max_rd_req_size)
            3'd0:    mx_qw <= `MAX_RD_QW_0;
            3'd1:    mx_qw <= `MAX_RD_QW_1;
            3'd2:    mx_qw <= `MAX_RD_QW_2;
            default: mx_qw <= `MAX_RD_QW_3;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // request FSM
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ibuf_rd_pkg::REQ_IDLE;
            rd          <= 1'b0;
            lbuf_dn     <= 1'b0;
            new_req_vld <= 1'b0;
            iprod       <= '0;
            issued_cnt  <= '0;
        end else begin
            lbuf_dn     <= 1'b0;
            new_req_vld <= 1'b0;
            case (state)
                ibuf_rd_pkg::REQ_IDLE: begin
                    hst_addr <= lbuf_addr;
                    qw_left  <= lbuf_len;
                    if (lbuf_en) state <= ibuf_rd_pkg::REQ_NEXT;
                end
                ibuf_rd_pkg::REQ_NEXT: begin
                    if (qw_left == '0) begin
                        lbuf_dn <= 1'b1;
                        state   <= ibuf_rd_pkg::REQ_DRAIN;
                    end else begin
                        state <= ibuf_rd_pkg::REQ_SIZE;
                    end
                end
                ibuf_rd_pkg::REQ_SIZE: begin
                    if (qw_left > ibuf_rd_pkg::xfer_len_t'(mx_qw)) req_qw <= mx_qw;
                    else req_qw <= qw_left[9:0];
                    state <= ibuf_rd_pkg::REQ_CHK;
                end
                ibuf_rd_pkg::REQ_CHK: begin
                    // wait for ring room and a free tag slot
                    if (need <= RING_QWS && os_req < OS_MAX) begin
                        rd    <= 1'b1;
                        rd_qw <= req_qw;
                        state <= ibuf_rd_pkg::REQ_RD;
                    end
                end
                ibuf_rd_pkg::REQ_RD: begin
                    if (rd_ack) begin
                        rd           <= 1'b0;
                        new_req.tag  <= rd_tag;
                        new_req.base <= iprod;
                        new_req.qws  <= rd_qw;
                        new_req_vld  <= 1'b1;
                        iprod        <= iprod + ibuf_rd_pkg::ibuf_ptr_t'(rd_qw);
                        hst_addr     <= hst_addr + ibuf_rd_pkg::host_addr_t'({rd_qw, 3'b000});
                        qw_left      <= qw_left - ibuf_rd_pkg::xfer_len_t'(rd_qw);
                        issued_cnt   <= issued_cnt + 1'b1;
                        state        <= ibuf_rd_pkg::REQ_NEXT;
                    end
                end
                ibuf_rd_pkg::REQ_DRAIN: begin
                    if (!lbuf_en) state <= ibuf_rd_pkg::REQ_IDLE;  // descriptor released
                end
                default: state <= ibuf_rd_pkg::REQ_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- ibuf_rd_pkg.sv
/*
 * ibuf read engine types
 * vector widths, stage-to-stage structs and FSM encodings
 */
`default_nettype none

`include "ibuf_rd_macros.svh"

package ibuf_rd_pkg;

    typedef logic [`IBUF_AW-1:0] ibuf_addr_t;  // ring slot
    typedef logic [`IBUF_AW:0]   ibuf_ptr_t;   // slot plus wrap bit
    typedef logic [`OSRW-1:0]    tag_t;
    typedef logic [`OSRW:0]      os_cnt_t;
    typedef logic [9:0]          qw_len_t;
    typedef logic [9:0]          dw_len_t;
    typedef logic [63:0]         host_addr_t;
    typedef logic [63:0]         qw_t;
    typedef logic [31:0]         xfer_len_t;

    // one receive beat, already active high
    typedef struct packed {
        qw_t  data;
        logic sof;
        logic eof;
        logic vld;
    } trn_beat_t;

    typedef struct packed {
        tag_t    tag;
        dw_len_t len;
    } cpl_hdr_t;

    typedef struct packed {
        tag_t      tag;
        ibuf_ptr_t base;   // first ring slot of the request
        qw_len_t   qws;
    } new_req_t;

    typedef enum logic [2:0] {
        REQ_IDLE, REQ_NEXT, REQ_SIZE, REQ_CHK, REQ_RD, REQ_DRAIN
    } req_state_t;

    typedef enum logic {WR_IDLE, WR_DATA} wr_state_t;

endpackage

`default_nettype wire

//--- ibuf_rd_macros.svh
/*
 * ibuf read engine constants
 * ring and tag widths, TLP codes and read request size limits
 */
`ifndef IBUF_RD_MACROS_SVH
`define IBUF_RD_MACROS_SVH

// ring and outstanding tags
`define IBUF_AW 9                      // 512 QW slots
`define OSRW 3                         // 8 tags in flight

// upper 5-OSRW bits of the TRN tag owned by this engine
`define RQ_TAG_BASE 2'b00

// completion header codes
`define CPL_W_DATA_FMT_TYPE 7'b1001010
`define CPL_STATUS_SC 3'b000

// max read request size code to QWs
`define MAX_RD_QW_0 16                 // 128 bytes
`define MAX_RD_QW_1 32                 // 256 bytes
`define MAX_RD_QW_2 64                 // 512 bytes
`define MAX_RD_QW_3 128                // 1 KB and above

`endif
